/* rtl/core_pkg.sv */
`default_nettype none

package core_pkg;

	//////////////////////////////////////////////////
	// Widths and counts
	//////////////////////////////////////////////////
	localparam int xlen       = 32; // Data path width
	localparam int reg_addr_w = 5;  // Register index width
	localparam int num_regs   = 32; // x0..x31

	typedef logic [xlen-1:0]       word_t;
	typedef logic [reg_addr_w-1:0] reg_addr_t;

	//////////////////////////////////////////////////
	// Instruction encodings
	//////////////////////////////////////////////////
	localparam logic [6:0] op_reg = 7'b0110011; // Register-register arithmetic
	localparam logic [6:0] op_imm = 7'b0010011; // Register-immediate arithmetic
	localparam logic [6:0] op_lui = 7'b0110111; // Load upper immediate

	localparam logic [6:0] funct7_base = 7'b0000000;
	localparam logic [6:0] funct7_alt  = 7'b0100000; // SUB, SRA, SRAI

	// funct3, same codes for R and I forms
	localparam logic [2:0] f3_add  = 3'b000; // ADD/SUB/ADDI
	localparam logic [2:0] f3_sll  = 3'b001;
	localparam logic [2:0] f3_slt  = 3'b010;
	localparam logic [2:0] f3_sltu = 3'b011;
	localparam logic [2:0] f3_xor  = 3'b100;
	localparam logic [2:0] f3_srl  = 3'b101; // SRL/SRA and immediate forms
	localparam logic [2:0] f3_or   = 3'b110;
	localparam logic [2:0] f3_and  = 3'b111;

	//////////////////////////////////////////////////
	// Control field types
	//////////////////////////////////////////////////
	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_sll,
		alu_slt,
		alu_sltu,
		alu_xor,
		alu_srl,
		alu_sra,
		alu_or,
		alu_and
	} alu_op_t;

	// Write-back source
	typedef enum logic {
		res_alu, // ALU output
		res_imm  // Upper immediate, LUI
	} res_sel_t;

endpackage

`default_nettype wire

/* rtl/inst_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
	input  wire core_pkg::word_t inst,
	output logic                 legal,
	output core_pkg::alu_op_t    alu_op,
	output logic                 use_imm,
	output core_pkg::res_sel_t   res_sel,
	output core_pkg::reg_addr_t  rd,
	output core_pkg::reg_addr_t  rs1,
	output core_pkg::reg_addr_t  rs2,
	output core_pkg::word_t      imm
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic       f7_base; // funct7 all zero
	logic       f7_alt;  // funct7 bit 5 set only

	// Instruction fields
	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];
	assign rd     = inst[11:7];
	assign rs1    = inst[19:15];
	assign rs2    = inst[24:20]; // Also shamt in I form

	assign f7_base  = (funct7 == core_pkg::funct7_base);
	assign f7_alt   = (funct7 == core_pkg::funct7_alt);

	// U immediate for LUI, sign-extended I immediate otherwise
	assign imm = (opcode == core_pkg::op_lui) ? {inst[31:12], 12'b0}
		: {{20{inst[31]}}, inst[31:20]};

	//////////////////////////////////////////////////
	// ALU operation from funct3
	//////////////////////////////////////////////////
	always_comb begin
		alu_op = core_pkg::alu_add;
		case (funct3)
			core_pkg::f3_add: begin
				if (f7_alt && (opcode == core_pkg::op_reg))
					alu_op = core_pkg::alu_sub; // No SUBI
			end
			core_pkg::f3_sll:  alu_op = core_pkg::alu_sll;
			core_pkg::f3_slt:  alu_op = core_pkg::alu_slt;
			core_pkg::f3_sltu: alu_op = core_pkg::alu_sltu;
			core_pkg::f3_xor:  alu_op = core_pkg::alu_xor;
			core_pkg::f3_srl:  alu_op = f7_alt ? core_pkg::alu_sra : core_pkg::alu_srl;
			core_pkg::f3_or:   alu_op = core_pkg::alu_or;
			default:           alu_op = core_pkg::alu_and;
		endcase
	end

	// Legality and operand / result selection per opcode
	always_comb begin
		legal   = 1'b0; // Anything unknown retires silently
		use_imm = 1'b0;
		res_sel = core_pkg::res_alu;
		case (opcode)
			core_pkg::op_reg: begin
				if ((funct3 == core_pkg::f3_add) || (funct3 == core_pkg::f3_srl))
					legal = f7_base || f7_alt;
				else
					legal = f7_base;
			end
			core_pkg::op_imm: begin
				use_imm = 1'b1;
				if (funct3 == core_pkg::f3_sll)
					legal = f7_base;         // SLLI
				else if (funct3 == core_pkg::f3_srl)
					legal = f7_base || f7_alt; // SRLI/SRAI
				else
					legal = 1'b1; // funct7 bits are immediate
			end
			core_pkg::op_lui: begin
				legal   = 1'b1;
				use_imm = 1'b1;
				res_sel = core_pkg::res_imm;
			end
			default: legal = 1'b0;
		endcase
	end

	// Immediate forms never decode to SUB
	always_comb begin
		if (legal && use_imm)
			assert (alu_op != core_pkg::alu_sub);
	end

endmodule

`default_nettype wire

/* rtl/decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
	input  wire                       CLK,
	input  wire                       rst,
	input  wire                       inst_valid,
	input  wire core_pkg::word_t      inst,
	input  wire core_pkg::word_t      rs1_data,
	input  wire core_pkg::word_t      rs2_data,
	input  wire core_pkg::word_t      exe_data,  // Execute result, combinational
	input  wire                       res_valid,
	input  wire core_pkg::reg_addr_t  res_rd,
	input  wire core_pkg::word_t      res_data,
	output core_pkg::reg_addr_t       rs1_addr,
	output core_pkg::reg_addr_t       rs2_addr,
	output logic                      ex_valid,
	output core_pkg::alu_op_t         ex_alu_op,
	output core_pkg::word_t           ex_op_a,
	output core_pkg::word_t           ex_op_b,
	output core_pkg::res_sel_t        ex_res_sel,
	output core_pkg::word_t           ex_imm,
	output core_pkg::reg_addr_t       ex_rd
);

	logic                dec_legal;
	core_pkg::alu_op_t   dec_alu_op;
	logic                dec_use_imm;
	core_pkg::res_sel_t  dec_res_sel;
	core_pkg::reg_addr_t dec_rd;
	core_pkg::reg_addr_t dec_rs1;
	core_pkg::reg_addr_t dec_rs2;
	core_pkg::word_t     dec_imm;

	logic            hit_ex_a, hit_ex_b;   // Match in execute
	logic            hit_res_a, hit_res_b; // Match in result stage
	core_pkg::word_t fwd_a, fwd_b;
	logic            issue;

	inst_decoder dec_i (
		.inst    (inst),
		.legal   (dec_legal),
		.alu_op  (dec_alu_op),
		.use_imm (dec_use_imm),
		.res_sel (dec_res_sel),
		.rd      (dec_rd),
		.rs1     (dec_rs1),
		.rs2     (dec_rs2),
		.imm     (dec_imm)
	);

	assign rs1_addr = dec_rs1; // To register file read ports
	assign rs2_addr = dec_rs2;

	//////////////////////////////////////////////////
	// Forwarding, execute before result stage
	//////////////////////////////////////////////////
	assign hit_ex_a  = ex_valid && (ex_rd == dec_rs1) && (dec_rs1 != '0);
	assign hit_ex_b  = ex_valid && (ex_rd == dec_rs2) && (dec_rs2 != '0);
	assign hit_res_a = res_valid && (res_rd == dec_rs1) && (dec_rs1 != '0);
	assign hit_res_b = res_valid && (res_rd == dec_rs2) && (dec_rs2 != '0);

	assign fwd_a = hit_ex_a ? exe_data : (hit_res_a ? res_data : rs1_data);
	assign fwd_b = hit_ex_b ? exe_data : (hit_res_b ? res_data : rs2_data);

	assign issue = inst_valid && dec_legal; // Illegal ones vanish here

	// Decode to execute register
	always_ff @(posedge CLK) begin
		if (rst)
			ex_valid <= 1'b0;
		else
			ex_valid <= issue;
	end

	always_ff @(posedge CLK) begin
		if (issue) begin
			ex_alu_op  <= dec_alu_op;
			ex_op_a    <= fwd_a;
			ex_op_b    <= dec_use_imm ? dec_imm : fwd_b; // Immediate replaces rs2
			ex_res_sel <= dec_res_sel;
			ex_imm     <= dec_imm;
			ex_rd      <= dec_rd;
		end
	end

	// Source x0 reaches execute as zero, never a forwarded x0 write
	a_x0_operand: assert property (@(posedge CLK) disable iff (rst)
		(issue && (dec_rs1 == '0)) |=> (ex_op_a == '0));

endmodule

`default_nettype wire

/* rtl/execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
	input  wire                       CLK,
	input  wire                       rst,
	input  wire                       ex_valid,
	input  wire core_pkg::alu_op_t    ex_alu_op,
	input  wire core_pkg::word_t      ex_op_a,
	input  wire core_pkg::word_t      ex_op_b,
	input  wire core_pkg::res_sel_t   ex_res_sel,
	input  wire core_pkg::word_t      ex_imm,
	input  wire core_pkg::reg_addr_t  ex_rd,
	output core_pkg::word_t           exe_data,
	output logic                      res_valid,
	output core_pkg::reg_addr_t       res_rd,
	output core_pkg::word_t           res_data
);

	logic [$clog2(core_pkg::xlen)-1:0] shamt; // Low bits of operand B
	logic                              lt_s;  // Signed less-than
	logic                              lt_u;  // Unsigned less-than
	core_pkg::word_t                   alu_res;

	assign shamt = ex_op_b[$clog2(core_pkg::xlen)-1:0];
	assign lt_s  = $signed(ex_op_a) < $signed(ex_op_b);
	assign lt_u  = ex_op_a < ex_op_b;

	//////////////////////////////////////////////////
	// ALU
	//////////////////////////////////////////////////
	always_comb begin
		case (ex_alu_op)
			core_pkg::alu_add:  alu_res = ex_op_a + ex_op_b;
			core_pkg::alu_sub:  alu_res = ex_op_a - ex_op_b;
			core_pkg::alu_sll:  alu_res = ex_op_a << shamt;
			core_pkg::alu_slt:  alu_res = core_pkg::word_t'(lt_s);
			core_pkg::alu_sltu: alu_res = core_pkg::word_t'(lt_u);
			core_pkg::alu_xor:  alu_res = ex_op_a ^ ex_op_b;
			core_pkg::alu_srl:  alu_res = ex_op_a >> shamt;
			core_pkg::alu_sra:  alu_res = $signed(ex_op_a) >>> shamt; // Sign fill
			core_pkg::alu_or:   alu_res = ex_op_a | ex_op_b;
			core_pkg::alu_and:  alu_res = ex_op_a & ex_op_b;
			default:            alu_res = '0;
		endcase
	end

	// LUI bypasses the ALU
	assign exe_data = (ex_res_sel == core_pkg::res_imm) ? ex_imm : alu_res;

	// Execute to result register
	always_ff @(posedge CLK) begin
		if (rst)
			res_valid <= 1'b0;
		else
			res_valid <= ex_valid;
	end

	always_ff @(posedge CLK) begin
		if (ex_valid) begin
			res_rd   <= ex_rd;
			res_data <= exe_data;
		end
	end

	// LUI value arrives with the low 12 bits clear
	a_lui_low_zero: assert property (@(posedge CLK) disable iff (rst)
		(ex_valid && (ex_res_sel == core_pkg::res_imm)) |-> (exe_data[11:0] == '0));

endmodule

`default_nettype wire

/* rtl/writeback_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module writeback_regfile (
	input  wire                       CLK,
	input  wire                       rst,
	input  wire                       res_valid,
	input  wire core_pkg::reg_addr_t  res_rd,
	input  wire core_pkg::word_t      res_data,
	input  wire core_pkg::reg_addr_t  rs1_addr,
	input  wire core_pkg::reg_addr_t  rs2_addr,
	output core_pkg::word_t           rs1_data,
	output core_pkg::word_t           rs2_data
);

	// x1..x31, x0 has no storage
	core_pkg::word_t regs [1:core_pkg::num_regs-1];

	//////////////////////////////////////////////////
	// Write port
	//////////////////////////////////////////////////
	always_ff @(posedge CLK) begin
		if (rst) begin
			for (int i = 1; i < core_pkg::num_regs; i++)
				regs[i] <= '0;
		end else if (res_valid && (res_rd != '0)) begin
			regs[res_rd] <= res_data; // x0 writes dropped
		end
	end

	// Read ports, no latency
	always_comb begin
		if (rs1_addr == '0)
			rs1_data = '0;
		else
			rs1_data = regs[rs1_addr];
	end

	always_comb begin
		if (rs2_addr == '0)
			rs2_data = '0;
		else
			rs2_data = regs[rs2_addr];
	end

	// Written value reads back on both ports in the next cycle
	a_write_read: assert property (@(posedge CLK) disable iff (rst)
		(res_valid && (res_rd != '0)) |=>
		((rs1_addr != $past(res_rd)) || (rs1_data == $past(res_data))) &&
		((rs2_addr != $past(res_rd)) || (rs2_data == $past(res_data))));

endmodule

`default_nettype wire

/* rtl/core.sv */
`timescale 1ns/1ps
`default_nettype none

module core (
	input  wire                   CLK,
	input  wire                   rst,
	input  wire                   inst_valid, // One-cycle strobe
	input  wire core_pkg::word_t  inst,
	output logic                  res_valid,  // Retired result strobe
	output core_pkg::reg_addr_t   res_rd,
	output core_pkg::word_t       res_data
);

	//////////////////////////////////////////////////
	// Stage interconnect
	//////////////////////////////////////////////////
	core_pkg::reg_addr_t rs1_addr, rs2_addr; // Decode to register file
	core_pkg::word_t     rs1_data, rs2_data;

	logic                ex_valid;
	core_pkg::alu_op_t   ex_alu_op;
	core_pkg::word_t     ex_op_a, ex_op_b;
	core_pkg::res_sel_t  ex_res_sel;
	core_pkg::word_t     ex_imm;
	core_pkg::reg_addr_t ex_rd;
	core_pkg::word_t     exe_data; // Forwarded from execute

	decode_stage decode_i (
		.CLK        (CLK),
		.rst        (rst),
		.inst_valid (inst_valid),
		.inst       (inst),
		.rs1_data   (rs1_data),
		.rs2_data   (rs2_data),
		.exe_data   (exe_data),
		.res_valid  (res_valid),
		.res_rd     (res_rd),
		.res_data   (res_data),
		.rs1_addr   (rs1_addr),
		.rs2_addr   (rs2_addr),
		.ex_valid   (ex_valid),
		.ex_alu_op  (ex_alu_op),
		.ex_op_a    (ex_op_a),
		.ex_op_b    (ex_op_b),
		.ex_res_sel (ex_res_sel),
		.ex_imm     (ex_imm),
		.ex_rd      (ex_rd)
	);

	execute_stage execute_i (
		.CLK        (CLK),
		.rst        (rst),
		.ex_valid   (ex_valid),
		.ex_alu_op  (ex_alu_op),
		.ex_op_a    (ex_op_a),
		.ex_op_b    (ex_op_b),
		.ex_res_sel (ex_res_sel),
		.ex_imm     (ex_imm),
		.ex_rd      (ex_rd),
		.exe_data   (exe_data),
		.res_valid  (res_valid),
		.res_rd     (res_rd),
		.res_data   (res_data)
	);

	// Result stage feeds the write port directly
	writeback_regfile regfile_i (
		.CLK       (CLK),
		.rst       (rst),
		.res_valid (res_valid),
		.res_rd    (res_rd),
		.res_data  (res_data),
		.rs1_addr  (rs1_addr),
		.rs2_addr  (rs2_addr),
		.rs1_data  (rs1_data),
		.rs2_data  (rs2_data)
	);

endmodule

`default_nettype wire

/* test/tb_model.svh */
`ifndef tb_model_svh
`define tb_model_svh

// Architectural registers as seen in program order
core_pkg::word_t mirror [0:core_pkg::num_regs-1];

//////////////////////////////////////////////////
// Instruction encoders
//////////////////////////////////////////////////
function automatic core_pkg::word_t r_type(input logic [6:0] f7, input core_pkg::reg_addr_t rs2,
	input core_pkg::reg_addr_t rs1, input logic [2:0] f3, input core_pkg::reg_addr_t rd);
	return {f7, rs2, rs1, f3, rd, core_pkg::op_reg};
endfunction

function automatic core_pkg::word_t i_type(input logic [11:0] imm, input core_pkg::reg_addr_t rs1,
	input logic [2:0] f3, input core_pkg::reg_addr_t rd);
	return {imm, rs1, f3, rd, core_pkg::op_imm}; // Shifts put funct7 in imm[11:5]
endfunction

function automatic core_pkg::word_t u_type(input logic [19:0] imm, input core_pkg::reg_addr_t rd);
	return {imm, rd, core_pkg::op_lui};
endfunction

//////////////////////////////////////////////////
// RV32I reference rules
//////////////////////////////////////////////////
function automatic logic is_legal(input core_pkg::word_t w);
	logic [6:0] f7;
	logic [2:0] f3;
	f7 = w[31:25];
	f3 = w[14:12];
	case (w[6:0])
		core_pkg::op_lui: return 1'b1;
		core_pkg::op_reg: return (f7 == core_pkg::funct7_base) ||
			((f7 == core_pkg::funct7_alt) && ((f3 == 3'd0) || (f3 == 3'd5))); // SUB, SRA only
		core_pkg::op_imm: begin
			if (f3 == 3'd1)
				return f7 == core_pkg::funct7_base; // SLLI
			if (f3 == 3'd5)
				return (f7 == core_pkg::funct7_base) || (f7 == core_pkg::funct7_alt);
			return 1'b1; // Upper bits are plain immediate
		end
		default: return 1'b0;
	endcase
endfunction

// Result of a legal instruction from the mirror
function automatic core_pkg::word_t expected_result(input core_pkg::word_t w);
	core_pkg::word_t    a, b;
	logic signed [31:0] sa, sb;
	logic               alt;
	a   = mirror[w[19:15]];
	b   = (w[6:0] == core_pkg::op_imm) ? {{20{w[31]}}, w[31:20]} : mirror[w[24:20]];
	sa  = a;
	sb  = b;
	alt = w[30] && ((w[6:0] == core_pkg::op_reg) || (w[14:12] == 3'd5)); // No SUBI
	if (w[6:0] == core_pkg::op_lui)
		return {w[31:12], 12'h000};
	case (w[14:12])
		3'd0: return alt ? a - b : a + b;
		3'd1: return a << b[4:0];
		3'd2: return {31'b0, sa < sb};
		3'd3: return {31'b0, a < b};
		3'd4: return a ^ b;
		3'd5: begin
			if (alt)
				return sa >>> b[4:0]; // Sign fill
			return a >> b[4:0];
		end
		3'd6: return a | b;
		default: return a & b;
	endcase
endfunction

`endif

/* test/tb_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_core;

	localparam int max_cycles = 2000; // About 3x the ~650 cycles of stimulus

	logic                CLK;
	logic                rst;
	logic                inst_valid;
	core_pkg::word_t     inst;
	logic                res_valid;
	core_pkg::reg_addr_t res_rd;
	core_pkg::word_t     res_data;

	integer              seed;
	logic                strobe_legal;    // Legal instruction strobed this cycle
	logic                legal_d1 = 1'b0;
	logic                legal_d2 = 1'b0; // Same strobe, two cycles later
	logic                rst_d = 1'b0;
	int                  cycles = 0;
	core_pkg::reg_addr_t exp_rd_q [$];    // Expected retirements in order
	core_pkg::word_t     exp_data_q [$];
	core_pkg::reg_addr_t want_rd;
	core_pkg::word_t     want_data;

	`include "tb_model.svh"

	core dut_i (
		.CLK        (CLK),
		.rst        (rst),
		.inst_valid (inst_valid),
		.inst       (inst),
		.res_valid  (res_valid),
		.res_rd     (res_rd),
		.res_data   (res_data)
	);

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	task automatic abort_run();
		$display("Errors found");
		$fatal(1);
	endtask

	// Strobe one instruction, model it at issue
	task automatic issue(input core_pkg::word_t word);
		core_pkg::word_t result;
		@(posedge CLK);
		#2;
		inst_valid   = 1'b1;
		inst         = word;
		strobe_legal = is_legal(word);
		if (strobe_legal) begin
			result = expected_result(word);
			exp_rd_q.push_back(word[11:7]);
			exp_data_q.push_back(result);
			if (word[11:7] != 5'd0)
				mirror[word[11:7]] = result; // x0 stays zero
		end
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge CLK);
			#2;
			inst_valid   = 1'b0;
			strobe_legal = 1'b0;
			inst         = $random(seed); // Junk on the bus while idle
		end
	endtask

	function automatic core_pkg::reg_addr_t any_reg();
		core_pkg::word_t r;
		r = $random(seed);
		return r[4:0];
	endfunction

	// kinds 4 gives R form only, 7 adds I form, 8 adds LUI
	function automatic core_pkg::word_t legal_word(input core_pkg::reg_addr_t rd,
		input core_pkg::reg_addr_t rs1, input core_pkg::reg_addr_t rs2, input int kinds);
		core_pkg::word_t r;
		logic [2:0]      f3;
		logic [6:0]      f7;
		int              kind;
		r    = $random(seed);
		f3   = r[14:12];
		kind = int'(r[31:29]) % kinds;
		f7   = core_pkg::funct7_base;
		if (((f3 == 3'd0) || (f3 == 3'd5)) && r[0])
			f7 = core_pkg::funct7_alt; // SUB, SRA, SRAI
		if (kind < 4)
			return r_type(f7, rs2, rs1, f3, rd);
		if (kind < 7) begin
			if ((f3 == 3'd1) || (f3 == 3'd5))
				return i_type({f7, r[24:20]}, rs1, f3, rd);
			return i_type(r[31:20], rs1, f3, rd);
		end
		return u_type(r[31:12], rd);
	endfunction

	// Bad funct7 on R form and shifts, or unknown opcode
	function automatic core_pkg::word_t illegal_word();
		core_pkg::word_t w;
		do begin
			w = $random(seed);
			if (w[8:7] == 2'd0)
				w[6:0] = core_pkg::op_reg;
			else if (w[8:7] == 2'd1) begin
				w[6:0]   = core_pkg::op_imm;
				w[13:12] = 2'b01; // SLLI or SRxI
			end
		end while (is_legal(w));
		return w;
	endfunction

	task automatic read_back_all();
		for (int r = 0; r < core_pkg::num_regs; r++)
			issue(i_type(12'h000, core_pkg::reg_addr_t'(r), 3'd0, core_pkg::reg_addr_t'(r)));
	endtask

	task automatic seed_registers();
		core_pkg::word_t v;
		for (int r = 1; r < core_pkg::num_regs; r++) begin
			v = $random(seed);
			issue(u_type(v[31:12], core_pkg::reg_addr_t'(r)));
			issue(i_type(v[11:0], core_pkg::reg_addr_t'(r), 3'd0, core_pkg::reg_addr_t'(r)));
		end
	endtask

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////
	always @(posedge CLK) begin
		legal_d1 <= strobe_legal;
		legal_d2 <= legal_d1;
		rst_d    <= rst;
	end

	a_latency: assert property (@(posedge CLK) disable iff (rst) res_valid == legal_d2)
		else begin
			$display("[ERROR] res_valid got %h expected %h", $sampled(res_valid),
				$sampled(legal_d2));
			abort_run();
		end

	a_quiet_reset: assert property (@(posedge CLK) rst_d |-> !res_valid)
		else begin
			$display("[ERROR] res_valid got %h expected 0 in reset", $sampled(res_valid));
			abort_run();
		end

	always @(negedge CLK) begin
		if (!rst && res_valid) begin
			if (exp_rd_q.size() == 0) begin
				$display("Result strobe arrived with no instruction outstanding");
				abort_run();
			end else begin
				want_rd   = exp_rd_q.pop_front();
				want_data = exp_data_q.pop_front();
				a_res_rd: assert (res_rd == want_rd) else begin
					$display("[ERROR] res_rd got %h expected %h", res_rd, want_rd);
					abort_run();
				end
				a_res_data: assert (res_data == want_data) else begin
					$display("[ERROR] res_data got %h expected %h", res_data, want_data);
					abort_run();
				end
			end
		end
	end

	always @(posedge CLK) begin
		cycles = cycles + 1;
		if (cycles >= max_cycles) begin
			$display("Timeout after %0d cycles with results still missing", cycles);
			abort_run();
		end
	end

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////
	initial begin
		core_pkg::reg_addr_t dep;
		core_pkg::word_t     gap;
		seed         = 12;
		rst          = 1'b1;
		inst_valid   = 1'b0;
		inst         = '0;
		strobe_legal = 1'b0;
		foreach (mirror[i])
			mirror[i] = '0;
		repeat (3) @(posedge CLK);
		#2;
		rst = 1'b0;

		read_back_all(); // Every register cleared by reset
		idle(2);

		seed_registers(); // Random full-width values, many negative
		repeat (160)
			issue(legal_word(any_reg(), any_reg(), any_reg(), 8));
		idle(2);

		// Chains at distance d hit execute, result stage, register file
		for (int d = 1; d <= 3; d++) begin
			for (int k = 0; k < 16; k++) begin
				dep = core_pkg::reg_addr_t'(10 + k % d);
				if (k % 2 == 1)
					issue(legal_word(dep, dep, any_reg(), 7));
				else
					issue(legal_word(dep, any_reg(), dep, 4));
			end
			idle(3);
		end

		issue(i_type(12'h07b, 5'd5, 3'd0, 5'd0)); // ADDI x0
		issue(r_type(core_pkg::funct7_base, 5'd6, 5'd7, 3'd0, 5'd0));
		issue(i_type(12'h000, 5'd0, 3'd0, 5'd1)); // x0 in execute and result stage
		issue(r_type(core_pkg::funct7_base, 5'd0, 5'd0, 3'd6, 5'd2));
		idle(3);

		repeat (8) begin
			issue(illegal_word());
			issue(illegal_word());
			issue(legal_word(any_reg(), any_reg(), any_reg(), 8));
		end
		idle(2);
		read_back_all(); // Nothing touched by the illegal ones
		idle(2);

		repeat (80) begin
			issue(legal_word(any_reg(), any_reg(), any_reg(), 8));
			gap = $random(seed);
			idle(int'(gap[1:0]));
		end
		repeat (60)
			issue(legal_word(any_reg(), any_reg(), any_reg(), 8));
		idle(1);

		while (exp_rd_q.size() != 0)
			idle(1);
		idle(3); // Catch any late extra strobe
		$display("No errors");
		$finish;
	end

endmodule

`default_nettype wire

/* src.f */
+incdir+test
rtl/core_pkg.sv
rtl/inst_decoder.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/writeback_regfile.sv
rtl/core.sv
test/tb_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the core testbench, then scan the log for a reported failure
verilator --binary --assert --top-module tb_core -f src.f -o tb_core_sim &&
	./obj_dir/tb_core_sim 2>&1 | tee sim.log &&
	! grep -q "Errors found" sim.log ||
	exit 1
